// ==== elink_defines.svh ====
`ifndef ELINK_DEFINES_SVH
`define ELINK_DEFINES_SVH

// Transaction field widths
`define ELINK_AW 32          // Address width
`define ELINK_DW 32          // Data width
`define ELINK_CW 4           // Ctrlmode width

// Path buffering
`define ELINK_FIFO_DEPTH 4   // Entries per path FIFO

// Shared memory geometry
`define ELINK_MEM_WORDS 256  // Depth in 32-bit words
`define ELINK_MEM_AW 8       // Word index, dstaddr bits 9..2

`endif

// ==== elink_pkg.sv ====
`include "elink_defines.svh"

package elink_pkg;

   // Transfer size, code 2'b11 is reserved and handled as a word
   typedef enum logic [1:0] {
      BYTE = 2'b00,                      // Single lane
      HALF = 2'b01,                      // Lane pair
      WORD = 2'b10                       // All four lanes
   } datamode_e;

   typedef struct packed {
      datamode_e            datamode;    // Write size
      logic [`ELINK_CW-1:0] ctrlmode;    // Passed along, not used by memory
      logic [`ELINK_AW-1:0] dstaddr;     // Target byte address
      logic [`ELINK_DW-1:0] data;        // Write data, lane aligned
   } emesh_wr_t;

   typedef struct packed {
      datamode_e            datamode;    // Read size, response is always a word
      logic [`ELINK_CW-1:0] ctrlmode;    // Echoed in the response
      logic [`ELINK_AW-1:0] dstaddr;     // Address to read
      logic [`ELINK_AW-1:0] srcaddr;     // Where the response goes
   } emesh_rq_t;

   typedef struct packed {
      logic [`ELINK_CW-1:0] ctrlmode;    // Copied from the request
      logic [`ELINK_AW-1:0] dstaddr;     // Requester's srcaddr
      logic [`ELINK_DW-1:0] data;        // Whole word
   } emesh_rr_t;

   typedef struct packed {
      logic                 write;       // 1 write, 0 read
      datamode_e            datamode;
      logic [`ELINK_CW-1:0] ctrlmode;
      logic [`ELINK_AW-1:0] addr;        // Memory byte address
      logic [`ELINK_DW-1:0] data;        // Zero on reads
      logic [`ELINK_AW-1:0] retaddr;     // Zero on writes
   } mem_op_t;

endpackage

// ==== emesh_fifo.sv ====
`timescale 1ns/100ps
`include "elink_defines.svh"

module emesh_fifo import elink_pkg::*; #(
   parameter type payload_t = emesh_wr_t,         // Item carried by this path
   parameter int  DEPTH     = `ELINK_FIFO_DEPTH   // Number of slots
) (
   input  logic     clkin,
   input  logic     reset,
   input  logic     in_valid,                     // Push side
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,                    // Pop side, head of queue
   input  logic     out_ready,
   output payload_t out_data
);

   localparam int              PW         = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int              CNTW       = $clog2(DEPTH + 1);
   localparam logic [PW-1:0]   LAST_PTR   = PW'(DEPTH - 1);
   localparam logic [CNTW-1:0] FULL_COUNT = CNTW'(DEPTH);

   payload_t        slots [DEPTH];                // Circular storage
   logic [PW-1:0]   wr_ptr;                       // Next slot to fill
   logic [PW-1:0]   rd_ptr;                       // Current head
   logic [CNTW-1:0] count;                        // Occupancy
   logic            push;
   logic            pop;

   assign in_ready  = (count != FULL_COUNT);      // Room left
   assign out_valid = (count != '0);              // Registered state only
   assign out_data  = slots[rd_ptr];              // Stable until popped
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;

   // Storage, no reset needed
   always_ff @(posedge clkin) begin
      if (push) begin
         slots[wr_ptr] <= in_data;
      end
   end

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;  // Wrap at depth
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNTW'(push) - CNTW'(pop);              // Push and pop may coincide
      end
   end

   // Pointers meet only when empty or full, any overflow or underflow breaks this
   a_ptr_sync: assert property (@(posedge clkin) disable iff (reset)
      ((count == '0) || (count == FULL_COUNT)) == (wr_ptr == rd_ptr))
      else $error("emesh_fifo pointers out of step with occupancy");

   a_count_bound: assert property (@(posedge clkin) disable iff (reset)
      count <= FULL_COUNT)
      else $error("emesh_fifo occupancy above depth");

endmodule

// ==== emesh_arbiter.sv ====
`timescale 1ns/100ps
`include "elink_defines.svh"

module emesh_arbiter import elink_pkg::*; (
   input  logic      wr_valid,          // Write FIFO head
   output logic      wr_ready,
   input  emesh_wr_t wr_data,
   input  logic      rq_valid,          // Read-request FIFO head
   output logic      rq_ready,
   input  emesh_rq_t rq_data,
   output logic      op_valid,          // Merged memory port
   input  logic      op_ready,
   output mem_op_t   op
);

   // Write head always wins, keeps reads behind earlier writes
   assign op_valid = wr_valid | rq_valid;
   assign wr_ready = wr_valid & op_ready;
   assign rq_ready = ~wr_valid & op_ready;   // Read only when no write waits

   always_comb begin
      if (wr_valid) begin
         op.write    = 1'b1;
         op.datamode = wr_data.datamode;
         op.ctrlmode = wr_data.ctrlmode;
         op.addr     = wr_data.dstaddr;
         op.data     = wr_data.data;
         op.retaddr  = {`ELINK_AW{1'b0}};  // No response for writes
      end else begin
         op.write    = 1'b0;
         op.datamode = rq_data.datamode;
         op.ctrlmode = rq_data.ctrlmode;    // Echoed back to requester
         op.addr     = rq_data.dstaddr;
         op.data     = {`ELINK_DW{1'b0}};  // Reads carry no data
         op.retaddr  = rq_data.srcaddr;     // Response destination
      end
   end

   // Only one FIFO may pop per cycle, else the memory sees a lost op
   always_comb begin
      a_one_grant: assert final (!(wr_ready && rq_ready))
         else $error("emesh_arbiter granted both paths");
   end

endmodule

// ==== emesh_memory.sv ====
`timescale 1ns/100ps
`include "elink_defines.svh"

module emesh_memory import elink_pkg::*; (
   input  logic      clkin,
   input  logic      reset,
   input  logic      op_valid,         // From arbiter
   output logic      op_ready,
   input  mem_op_t   op,
   output logic      out_valid,        // Read response
   input  logic      out_ready,
   output emesh_rr_t out_data
);

   logic [`ELINK_DW-1:0]     words [`ELINK_MEM_WORDS];  // Main array
   logic [`ELINK_MEM_AW-1:0] index;                     // Word select
   logic [3:0]               lane_en;                   // Byte write enables
   logic                     wr_en;
   logic                     rd_en;

   assign index = op.addr[`ELINK_MEM_AW+1:2];  // Bits above 9 ignored

   // Lane decode from size and low address bits
   always_comb begin
      case (op.datamode)
         BYTE:    lane_en = 4'b0001 << op.addr[1:0];
         HALF:    lane_en = op.addr[1] ? 4'b1100 : 4'b0011;
         default: lane_en = 4'b1111;            // WORD and reserved code
      endcase
   end

   // Writes never stall, reads need a free or draining slot
   assign op_ready = op.write | ~out_valid | out_ready;
   assign wr_en    = op_valid & op.write;
   assign rd_en    = op_valid & ~op.write & op_ready;

   always_ff @(posedge clkin) begin
      for (int i = 0; i < 4; i++) begin
         if (wr_en && lane_en[i]) begin
            words[index][8*i +: 8] <= op.data[8*i +: 8];  // Matching lane of data
         end
      end
   end

   // Response slot occupancy
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (rd_en) begin
         out_valid <= 1'b1;                  // New response, replaces a drained one
      end else if (out_ready) begin
         out_valid <= 1'b0;                  // Drained
      end
   end

   // Response payload, loaded only on an accepted read
   always_ff @(posedge clkin) begin
      if (rd_en) begin
         out_data.ctrlmode <= op.ctrlmode;
         out_data.dstaddr  <= op.retaddr;    // Back to requester
         out_data.data     <= words[index];  // Whole word regardless of size
      end
   end

   // Held response must not change under back-pressure
   a_rsp_hold: assert property (@(posedge clkin) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
      else $error("emesh_memory response changed before acceptance");

endmodule

// ==== elink_loopback.sv ====
`timescale 1ns/100ps
`include "elink_defines.svh"

module elink_loopback import elink_pkg::*; (
   input  logic                 clkin,
   input  logic                 reset,
   input  logic                 in_valid,      // Incoming transaction
   output logic                 in_ready,
   input  logic                 in_write,      // Selects the path
   input  datamode_e            in_datamode,
   input  logic [`ELINK_CW-1:0] in_ctrlmode,
   input  logic [`ELINK_AW-1:0] in_dstaddr,
   input  logic [`ELINK_DW-1:0] in_data,       // Ignored on reads
   input  logic [`ELINK_AW-1:0] in_srcaddr,    // Ignored on writes
   output logic                 out_valid,     // Read response
   input  logic                 out_ready,
   output logic [`ELINK_CW-1:0] out_ctrlmode,
   output logic [`ELINK_AW-1:0] out_dstaddr,
   output logic [`ELINK_DW-1:0] out_data
);

   // Write path
   emesh_wr_t wr_in;
   logic      wr_in_valid;
   logic      wr_in_ready;
   emesh_wr_t wr_head;
   logic      wr_head_valid;
   logic      wr_head_ready;

   // Read-request path
   emesh_rq_t rq_in;
   logic      rq_in_valid;
   logic      rq_in_ready;
   emesh_rq_t rq_head;
   logic      rq_head_valid;
   logic      rq_head_ready;

   // Memory port and response
   mem_op_t   op;
   logic      op_valid;
   logic      op_ready;
   emesh_rr_t rsp;

   // Split by write bit, pushback from the chosen FIFO only
   assign wr_in_valid = in_valid & in_write;
   assign rq_in_valid = in_valid & ~in_write;
   assign in_ready    = in_write ? wr_in_ready : rq_in_ready;

   assign wr_in = '{datamode: in_datamode, ctrlmode: in_ctrlmode,
                    dstaddr: in_dstaddr, data: in_data};
   assign rq_in = '{datamode: in_datamode, ctrlmode: in_ctrlmode,
                    dstaddr: in_dstaddr, srcaddr: in_srcaddr};

   emesh_fifo #(.payload_t(emesh_wr_t), .DEPTH(`ELINK_FIFO_DEPTH)) wr_fifo (
      .clkin     (clkin),
      .reset     (reset),
      .in_valid  (wr_in_valid),
      .in_ready  (wr_in_ready),
      .in_data   (wr_in),
      .out_valid (wr_head_valid),
      .out_ready (wr_head_ready),
      .out_data  (wr_head)
   );

   emesh_fifo #(.payload_t(emesh_rq_t), .DEPTH(`ELINK_FIFO_DEPTH)) rq_fifo (
      .clkin     (clkin),
      .reset     (reset),
      .in_valid  (rq_in_valid),
      .in_ready  (rq_in_ready),
      .in_data   (rq_in),
      .out_valid (rq_head_valid),
      .out_ready (rq_head_ready),
      .out_data  (rq_head)
   );

   emesh_arbiter arbiter (
      .wr_valid (wr_head_valid),
      .wr_ready (wr_head_ready),
      .wr_data  (wr_head),
      .rq_valid (rq_head_valid),
      .rq_ready (rq_head_ready),
      .rq_data  (rq_head),
      .op_valid (op_valid),
      .op_ready (op_ready),
      .op       (op)
   );

   emesh_memory memory (
      .clkin     (clkin),
      .reset     (reset),
      .op_valid  (op_valid),
      .op_ready  (op_ready),
      .op        (op),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (rsp)
   );

   // Unpack response onto loose ports
   assign out_ctrlmode = rsp.ctrlmode;
   assign out_dstaddr  = rsp.dstaddr;
   assign out_data     = rsp.data;

endmodule

// ==== tb_elink_loopback.sv ====
`timescale 1ns/100ps
`include "elink_defines.svh"

module tb_elink_loopback import elink_pkg::*; ();

   localparam int CYCLE_LIMIT = 2000;            // 24 entries x ~20 worst-case cycles, margin

   typedef struct packed {
      logic                 write;
      logic [1:0]           mode;
      logic [`ELINK_CW-1:0] ctrl;
      logic [`ELINK_AW-1:0] dst;
      logic [`ELINK_DW-1:0] data;
      logic [`ELINK_AW-1:0] src;
   } stim_t;

   typedef struct packed {
      logic [`ELINK_CW-1:0] ctrl;
      logic [`ELINK_AW-1:0] dst;
      logic [`ELINK_DW-1:0] data;
   } rsp_t;

   logic                 clkin;
   logic                 reset;
   logic                 in_valid;
   logic                 in_ready;
   logic                 in_write;
   datamode_e            in_datamode;
   logic [`ELINK_CW-1:0] in_ctrlmode;
   logic [`ELINK_AW-1:0] in_dstaddr;
   logic [`ELINK_DW-1:0] in_data;
   logic [`ELINK_AW-1:0] in_srcaddr;
   logic                 out_valid;
   logic                 out_ready;
   logic [`ELINK_CW-1:0] out_ctrlmode;
   logic [`ELINK_AW-1:0] out_dstaddr;
   logic [`ELINK_DW-1:0] out_data;

   stim_t       stim [$];                        // Stimulus table
   rsp_t        exp_q [$];                       // Responses still owed
   logic [7:0]  model [`ELINK_MEM_WORDS][4];     // Byte-lane reference memory
   logic [31:0] rng = 32'hda007d51;
   int          cycles = 0;

   elink_loopback UUT (
      .clkin        (clkin),
      .reset        (reset),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .in_write     (in_write),
      .in_datamode  (in_datamode),
      .in_ctrlmode  (in_ctrlmode),
      .in_dstaddr   (in_dstaddr),
      .in_data      (in_data),
      .in_srcaddr   (in_srcaddr),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .out_ctrlmode (out_ctrlmode),
      .out_dstaddr  (out_dstaddr),
      .out_data     (out_data)
   );

   initial begin
      clkin = 1'b0;
      forever #4 clkin = ~clkin;                 // 8 ns period
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   task automatic stop_run();
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, expected);
      stop_run();
   endtask

   task automatic report_error(input string what);
      $display("Error at t=%0t: %s", $time, what);
      stop_run();
   endtask

   task automatic add_entry(input logic write, input logic [1:0] mode,
                            input logic [3:0] ctrl, input logic [31:0] dst,
                            input logic [31:0] data, input logic [31:0] src);
      stim.push_back('{write, mode, ctrl, dst, data, src});
   endtask

   // Lanes chosen by size and low address bits, bits above 9 dropped
   task automatic apply_write(input logic [1:0] mode, input logic [31:0] addr,
                              input logic [31:0] data);
      logic hit;
      for (int i = 0; i < 4; i++) begin
         if (mode == 2'b00) hit = (i[1:0] == addr[1:0]);   // One lane
         else if (mode == 2'b01) hit = (i[1] == addr[1]);  // Lane pair
         else hit = 1'b1;                                  // Word, reserved too
         if (hit) model[addr[9:2]][i] = data[8*i +: 8];
      end
   endtask

   function automatic logic [31:0] word_at(input logic [31:0] addr);
      return {model[addr[9:2]][3], model[addr[9:2]][2], model[addr[9:2]][1],
              model[addr[9:2]][0]};
   endfunction

   task automatic check_response(input rsp_t e);
      assert (out_ctrlmode === e.ctrl)
         else report_mismatch("out_ctrlmode", 32'(out_ctrlmode), 32'(e.ctrl));
      assert (out_dstaddr === e.dst)
         else report_mismatch("out_dstaddr", out_dstaddr, e.dst);
      assert (out_data === e.data)
         else report_mismatch("out_data", out_data, e.data);
   endtask

   always @(posedge clkin) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) report_error("timeout, responses never completed");
   end

   initial begin
      int    idx;
      logic  held;
      stim_t s;
      rsp_t  e;
      rsp_t  held_rsp;
      reset = 1'b1;
      in_valid = 1'b0;
      in_write = 1'b0;
      in_datamode = WORD;
      in_ctrlmode = '0;
      in_dstaddr = '0;
      in_data = '0;
      in_srcaddr = '0;
      out_ready = 1'b0;
      s = '0;
      add_entry(1, WORD, 4'h1, 32'h0000_0010, 32'h1122_3344, 32'h0);  // Word then read back
      add_entry(0, WORD, 4'h5, 32'h0000_0010, 32'h0, 32'h0000_a000);
      add_entry(1, WORD, 4'h2, 32'h0000_0020, 32'hdead_beef, 32'h0);  // Lane merge
      add_entry(1, BYTE, 4'h2, 32'h0000_0021, 32'h0000_5a00, 32'h0);
      add_entry(1, HALF, 4'h2, 32'h0000_0022, 32'h1234_0000, 32'h0);
      add_entry(1, BYTE, 4'h3, 32'h0000_0020, 32'h0000_00c3, 32'h0);
      add_entry(0, BYTE, 4'h9, 32'h0000_0023, 32'h0, 32'h0000_b004);
      add_entry(1, WORD, 4'h4, 32'h0000_0040, 32'h0bad_f00d, 32'h0);  // Alternating
      add_entry(0, WORD, 4'ha, 32'h0000_0040, 32'h0, 32'h0000_c000);
      add_entry(1, WORD, 4'h4, 32'h0000_0044, 32'h600d_cafe, 32'h0);
      add_entry(0, WORD, 4'hb, 32'h0000_0044, 32'h0, 32'h0000_c004);
      add_entry(1, WORD, 4'h4, 32'h0000_0048, 32'h1357_9bdf, 32'h0);
      add_entry(0, HALF, 4'hc, 32'h0000_0048, 32'h0, 32'h0000_c008);
      add_entry(1, WORD, 4'h4, 32'h0000_004c, 32'h2468_ace0, 32'h0);
      add_entry(0, WORD, 4'hd, 32'h0000_004c, 32'h0, 32'h0000_c00c);
      add_entry(0, WORD, 4'h6, 32'h0000_0410, 32'h0, 32'h0000_d000);  // Aliases above bit 9
      add_entry(0, WORD, 4'h7, 32'hffff_fc10, 32'h0, 32'h0000_d004);
      add_entry(0, WORD, 4'h8, 32'h8000_0020, 32'h0, 32'h0000_d008);
      add_entry(1, 2'b11, 4'he, 32'h0000_0080, 32'ha5a5_5a5a, 32'h0);  // Reserved size
      add_entry(0, WORD, 4'hf, 32'h0000_0080, 32'h0, 32'h0000_e000);
      add_entry(1, WORD, 4'h1, 32'h0000_0060, 32'h0000_0000, 32'h0);  // Upper half then byte
      add_entry(1, HALF, 4'h1, 32'h0000_0063, 32'hfeed_0000, 32'h0);
      add_entry(1, BYTE, 4'h1, 32'h0000_0062, 32'h0077_0000, 32'h0);
      add_entry(0, WORD, 4'h3, 32'h0000_0060, 32'h0, 32'h0000_e004);
      repeat (8) @(posedge clkin);
      @(negedge clkin);
      reset = 1'b0;
      #1;
      assert (out_valid === 1'b0) else report_error("out_valid high after reset");
      assert (in_ready === 1'b1) else report_error("in_ready low after reset");
      idx = 0;
      held = 1'b0;
      while (idx < stim.size() || exp_q.size() != 0) begin
         @(negedge clkin);
         if (held) begin                          // Response stalled at the last edge
            assert (out_valid === 1'b1) else report_error("response dropped before acceptance");
            check_response(held_rsp);
         end
         if (idx < stim.size()) begin
            s = stim[idx];
            in_valid = 1'b1;
            in_write = s.write;
            in_datamode = datamode_e'(s.mode);
            in_ctrlmode = s.ctrl;
            in_dstaddr = s.dst;
            in_data = s.write ? s.data : rng;    // Junk data on reads
            in_srcaddr = s.src;
         end else begin
            in_valid = 1'b0;
         end
         rng = xorshift32(rng);
         out_ready = rng[0];                      // Random back-pressure
         #1;
         if (in_valid && in_ready) begin          // Taken at the next rising edge
            if (s.write) apply_write(s.mode, s.dst, s.data);
            else exp_q.push_back('{s.ctrl, s.src, word_at(s.dst)});
            idx++;
         end
         held = 1'b0;
         if (out_valid === 1'b1) begin
            if (out_ready) begin
               assert (exp_q.size() != 0) else report_error("response with no read outstanding");
               e = exp_q.pop_front();
               check_response(e);
            end else begin
               held = 1'b1;
               held_rsp = '{out_ctrlmode, out_dstaddr, out_data};
            end
         end
      end
      repeat (10) begin                           // No stray responses afterwards
         @(negedge clkin);
         in_valid = 1'b0;
         out_ready = 1'b1;
         #1;
         assert (out_valid === 1'b0) else report_error("more responses than reads");
      end
      if (exp_q.size() == 0) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         report_error("expected responses left over");
      end
   end

endmodule

// ==== list.f ====
+incdir+.
elink_pkg.sv
emesh_fifo.sv
emesh_arbiter.sv
emesh_memory.sv
elink_loopback.sv
tb_elink_loopback.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
   --top-module tb_elink_loopback -o tb_sim > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "No pass message in log"; exit 1; }
exit 0
